/* include/rsv_consts.svh */
`ifndef RSV_CONSTS_SVH
`define RSV_CONSTS_SVH

// station geometry
`define RSV_ENTRY_NUMS	8
`define RSV_IDX_WIDTH	3

// physical register file
`define PRF_NUMS		32
`define PRF_CODE_WIDTH	5
`define PRF_DATA_WIDTH	32

// micro-op fields
`define ROB_ID_WIDTH	5
`define IMM_WIDTH		20

// writeback and issue ports
`define WB_PORTS		2
`define ISSUE_PORTS		2

// two source reads per issue port
`define PRF_RD_PORTS	(2 * `ISSUE_PORTS)

`endif

/* verilog/rsv_pkg.sv */
`include "rsv_consts.svh"

package rsv_pkg;

	typedef logic [`PRF_CODE_WIDTH - 1 : 0]	prf_code_t;
	typedef logic [`PRF_DATA_WIDTH - 1 : 0]	prf_data_t;
	typedef logic [`ROB_ID_WIDTH - 1 : 0]	rob_id_t;
	typedef logic [`IMM_WIDTH - 1 : 0]		imm_t;
	typedef logic [`RSV_ENTRY_NUMS - 1 : 0]	rsv_vec_t;
	typedef logic [`RSV_IDX_WIDTH - 1 : 0]	rsv_idx_t;

	typedef enum logic [0 : 0] {
		EXEC_ALU	= 1'b0,
		EXEC_MULDIV	= 1'b1
	} exec_unit_e;

	typedef struct packed {
		exec_unit_e	unit;
		logic		src1_vld;
		prf_code_t	src1_code;
		logic		src2_vld;
		prf_code_t	src2_code;
		logic		dst_vld;
		prf_code_t	dst_code;
		rob_id_t	rob_id;
		imm_t		imm;
	} rsv_dsp_t;

	typedef struct packed {
		logic		vld;
		prf_code_t	code;
		prf_data_t	data;
	} rsv_wb_t;

	typedef struct packed {
		logic		vld;
		rob_id_t	rob_id;
		logic		dst_vld;
		prf_code_t	dst_code;
		imm_t		imm;
		prf_data_t	src1_data;
		prf_data_t	src2_data;
	} rsv_issue_t;

endpackage

/* verilog/rsv_age_mtrx.sv */
`timescale 1ns/1ps
`include "rsv_consts.svh"

module rsv_age_mtrx (
	input  logic				clk,
	input  logic				i_arst_n,
	input  logic				i_flush,
	input  rsv_pkg::rsv_vec_t	i_alloc_vec,
	input  logic				i_alloc_mine,
	input  rsv_pkg::rsv_vec_t	i_entry_vld_vec,
	input  rsv_pkg::rsv_vec_t	i_req_vec,
	output rsv_pkg::rsv_vec_t	o_oldest_vec
);

	// row i holds the entries older than entry i
	rsv_pkg::rsv_vec_t [`RSV_ENTRY_NUMS - 1 : 0]	age_q;
	logic											alloc_any;

	assign alloc_any = |i_alloc_vec;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			age_q <= '0;
		end else if (i_flush) begin
			age_q <= '0;
		end else if (alloc_any) begin
			for (int i = 0; i < `RSV_ENTRY_NUMS; i++) begin
				if (i_alloc_vec[i]) begin
					if (i_alloc_mine) begin
						age_q[i] <= i_entry_vld_vec;
					end else begin
						age_q[i] <= '0;
					end
				end else begin
					// new entry is younger than everyone
					age_q[i] <= age_q[i] & ~i_alloc_vec;
				end
			end
		end
	end

	// oldest requester has no older requester in its row
	always_comb begin
		for (int i = 0; i < `RSV_ENTRY_NUMS; i++) begin
			o_oldest_vec[i] = i_req_vec[i] & ~(|(age_q[i] & i_req_vec));
		end
	end

endmodule

/* verilog/rsv_src_tag.sv */
`timescale 1ns/1ps
`include "rsv_consts.svh"

module rsv_src_tag (
	input  logic											clk,
	input  logic											i_arst_n,
	input  rsv_pkg::rsv_vec_t								i_alloc_vec,
	input  rsv_pkg::rsv_dsp_t								i_dsp_uop,
	input  logic [`PRF_NUMS - 1 : 0]						i_prf_rdy,
	input  rsv_pkg::rsv_wb_t [`WB_PORTS - 1 : 0]			i_wb,
	input  rsv_pkg::rsv_vec_t								i_issue_vec,
	output rsv_pkg::rsv_vec_t								o_src_rdy,
	output rsv_pkg::prf_code_t [`RSV_ENTRY_NUMS - 1 : 0]	o_src1_code,
	output rsv_pkg::prf_code_t [`RSV_ENTRY_NUMS - 1 : 0]	o_src2_code
);

	rsv_pkg::prf_code_t [`RSV_ENTRY_NUMS - 1 : 0]	src1_code_q;
	rsv_pkg::prf_code_t [`RSV_ENTRY_NUMS - 1 : 0]	src2_code_q;
	rsv_pkg::rsv_vec_t								src1_rdy_q;
	rsv_pkg::rsv_vec_t								src2_rdy_q;
	logic											dsp_src1_rdy;
	logic											dsp_src2_rdy;

	function automatic logic wb_hit(input rsv_pkg::prf_code_t code);
		logic hit;
		hit = 1'b0;
		for (int p = 0; p < `WB_PORTS; p++) begin
			hit = hit | (i_wb[p].vld && (i_wb[p].code == code));
		end
		return hit;
	endfunction

	// readiness seen at dispatch, including a writeback in the same cycle
	assign dsp_src1_rdy = !i_dsp_uop.src1_vld || i_prf_rdy[i_dsp_uop.src1_code]
						|| wb_hit(i_dsp_uop.src1_code);
	assign dsp_src2_rdy = !i_dsp_uop.src2_vld || i_prf_rdy[i_dsp_uop.src2_code]
						|| wb_hit(i_dsp_uop.src2_code);

	always_ff @(posedge clk) begin
		for (int i = 0; i < `RSV_ENTRY_NUMS; i++) begin
			if (i_alloc_vec[i]) begin
				src1_code_q[i] <= i_dsp_uop.src1_code;
				src2_code_q[i] <= i_dsp_uop.src2_code;
			end
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			src1_rdy_q <= '0;
			src2_rdy_q <= '0;
		end else begin
			for (int i = 0; i < `RSV_ENTRY_NUMS; i++) begin
				if (i_alloc_vec[i]) begin
					src1_rdy_q[i] <= dsp_src1_rdy;
					src2_rdy_q[i] <= dsp_src2_rdy;
				end else if (i_issue_vec[i]) begin
					src1_rdy_q[i] <= 1'b0;
					src2_rdy_q[i] <= 1'b0;
				end else begin
					// wakeup
					if (wb_hit(src1_code_q[i])) begin
						src1_rdy_q[i] <= 1'b1;
					end
					if (wb_hit(src2_code_q[i])) begin
						src2_rdy_q[i] <= 1'b1;
					end
				end
			end
		end
	end

	assign o_src_rdy   = src1_rdy_q & src2_rdy_q;
	assign o_src1_code = src1_code_q;
	assign o_src2_code = src2_code_q;

endmodule

/* verilog/rsv_ctrl.sv */
`timescale 1ns/1ps
`include "rsv_consts.svh"

module rsv_ctrl (
	input  logic											clk,
	input  logic											i_arst_n,
	input  logic											i_flush,
	input  logic											i_dsp_vld,
	input  rsv_pkg::rsv_dsp_t								i_dsp_uop,
	input  rsv_pkg::rsv_vec_t								i_src_rdy,
	input  rsv_pkg::prf_code_t [`RSV_ENTRY_NUMS - 1 : 0]	i_src1_code,
	input  rsv_pkg::prf_code_t [`RSV_ENTRY_NUMS - 1 : 0]	i_src2_code,
	input  rsv_pkg::rsv_vec_t								i_oldest_alu,
	input  rsv_pkg::rsv_vec_t								i_oldest_muldiv,
	input  rsv_pkg::prf_data_t [`PRF_RD_PORTS - 1 : 0]		i_prf_rdat,
	output rsv_pkg::rsv_vec_t								o_alloc_vec,
	output rsv_pkg::rsv_vec_t								o_alu_vld,
	output rsv_pkg::rsv_vec_t								o_muldiv_vld,
	output rsv_pkg::rsv_vec_t								o_alu_req,
	output rsv_pkg::rsv_vec_t								o_muldiv_req,
	output rsv_pkg::rsv_vec_t								o_issue_vec,
	output rsv_pkg::prf_code_t [`PRF_RD_PORTS - 1 : 0]		o_prf_rd_code,
	output logic											o_rsv_full,
	output rsv_pkg::rsv_issue_t [`ISSUE_PORTS - 1 : 0]		o_issue
);

	rsv_pkg::rsv_vec_t									entry_vld_q;
	rsv_pkg::exec_unit_e [`RSV_ENTRY_NUMS - 1 : 0]		unit_q;
	rsv_pkg::rob_id_t [`RSV_ENTRY_NUMS - 1 : 0]			rob_id_q;
	logic [`RSV_ENTRY_NUMS - 1 : 0]						dst_vld_q;
	rsv_pkg::prf_code_t [`RSV_ENTRY_NUMS - 1 : 0]		dst_code_q;
	rsv_pkg::imm_t [`RSV_ENTRY_NUMS - 1 : 0]			imm_q;
	rsv_pkg::rsv_vec_t									free_vec;
	rsv_pkg::rsv_vec_t									muldiv_vec;
	rsv_pkg::rsv_vec_t [`ISSUE_PORTS - 1 : 0]			oldest;
	rsv_pkg::rsv_idx_t [`ISSUE_PORTS - 1 : 0]			sel_idx;
	rsv_pkg::rsv_issue_t [`ISSUE_PORTS - 1 : 0]			issue_nxt;
	rsv_pkg::rsv_issue_t [`ISSUE_PORTS - 1 : 0]			issue_q;
	logic [`ISSUE_PORTS - 1 : 0]						issue_vld_q;

	function automatic rsv_pkg::rsv_idx_t vec2idx(input rsv_pkg::rsv_vec_t vec);
		rsv_pkg::rsv_idx_t idx;
		idx = '0;
		for (int i = 0; i < `RSV_ENTRY_NUMS; i++) begin
			if (vec[i]) begin
				idx = idx | rsv_pkg::rsv_idx_t'(i);
			end
		end
		return idx;
	endfunction

	assign free_vec   = ~entry_vld_q;
	assign o_rsv_full = &entry_vld_q;

	// lowest free entry, dropped when full or flushing
	assign o_alloc_vec = (i_dsp_vld && !o_rsv_full && !i_flush)
					   ? (free_vec & (~free_vec + rsv_pkg::rsv_vec_t'(1))) : '0;

	always_comb begin
		for (int i = 0; i < `RSV_ENTRY_NUMS; i++) begin
			muldiv_vec[i] = (unit_q[i] == rsv_pkg::EXEC_MULDIV);
		end
	end

	assign o_alu_vld    = entry_vld_q & ~muldiv_vec;
	assign o_muldiv_vld = entry_vld_q & muldiv_vec;
	assign o_alu_req    = o_alu_vld & i_src_rdy;
	assign o_muldiv_req = o_muldiv_vld & i_src_rdy;

	// port 0 alu, port 1 muldiv
	assign oldest[0]   = i_oldest_alu;
	assign oldest[1]   = i_oldest_muldiv;
	assign o_issue_vec = i_oldest_alu | i_oldest_muldiv;

	always_comb begin
		for (int p = 0; p < `ISSUE_PORTS; p++) begin
			sel_idx[p]					= vec2idx(oldest[p]);
			o_prf_rd_code[2 * p]		= i_src1_code[sel_idx[p]];
			o_prf_rd_code[2 * p + 1]	= i_src2_code[sel_idx[p]];
			issue_nxt[p].vld			= |oldest[p];
			issue_nxt[p].rob_id			= rob_id_q[sel_idx[p]];
			issue_nxt[p].dst_vld		= dst_vld_q[sel_idx[p]];
			issue_nxt[p].dst_code		= dst_code_q[sel_idx[p]];
			issue_nxt[p].imm			= imm_q[sel_idx[p]];
			issue_nxt[p].src1_data		= i_prf_rdat[2 * p];
			issue_nxt[p].src2_data		= i_prf_rdat[2 * p + 1];
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			entry_vld_q <= '0;
		end else if (i_flush) begin
			entry_vld_q <= '0;
		end else begin
			entry_vld_q <= (entry_vld_q & ~o_issue_vec) | o_alloc_vec;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `RSV_ENTRY_NUMS; i++) begin
			if (o_alloc_vec[i]) begin
				unit_q[i]		<= i_dsp_uop.unit;
				rob_id_q[i]		<= i_dsp_uop.rob_id;
				dst_vld_q[i]	<= i_dsp_uop.dst_vld;
				dst_code_q[i]	<= i_dsp_uop.dst_code;
				imm_q[i]		<= i_dsp_uop.imm;
			end
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			issue_vld_q <= '0;
		end else begin
			for (int p = 0; p < `ISSUE_PORTS; p++) begin
				issue_vld_q[p] <= issue_nxt[p].vld & ~i_flush;
			end
		end
	end

	always_ff @(posedge clk) begin
		issue_q <= issue_nxt;
	end

	always_comb begin
		o_issue = issue_q;
		for (int p = 0; p < `ISSUE_PORTS; p++) begin
			o_issue[p].vld = issue_vld_q[p];
		end
	end

endmodule

/* verilog/rsv_prf.sv */
`timescale 1ns/1ps
`include "rsv_consts.svh"

module rsv_prf (
	input  logic										clk,
	input  logic										i_arst_n,
	input  rsv_pkg::rsv_wb_t [`WB_PORTS - 1 : 0]		i_wb,
	input  logic										i_dsp_vld,
	input  rsv_pkg::rsv_dsp_t							i_dsp_uop,
	input  rsv_pkg::prf_code_t [`PRF_RD_PORTS - 1 : 0]	i_rd_code,
	output rsv_pkg::prf_data_t [`PRF_RD_PORTS - 1 : 0]	o_rdat,
	output logic [`PRF_NUMS - 1 : 0]					o_prf_rdy
);

	rsv_pkg::prf_data_t	mem_q [`PRF_NUMS];
	logic [`PRF_NUMS - 1 : 0]	rdy_q;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int r = 0; r < `PRF_NUMS; r++) begin
				mem_q[r] <= '0;
			end
		end else begin
			// later port wins on a shared code
			for (int p = 0; p < `WB_PORTS; p++) begin
				if (i_wb[p].vld) begin
					mem_q[i_wb[p].code] <= i_wb[p].data;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rdy_q <= '1;
		end else begin
			if (i_dsp_vld && i_dsp_uop.dst_vld) begin
				rdy_q[i_dsp_uop.dst_code] <= 1'b0;
			end
			// a writeback to the same code overrides the clear
			for (int p = 0; p < `WB_PORTS; p++) begin
				if (i_wb[p].vld) begin
					rdy_q[i_wb[p].code] <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int r = 0; r < `PRF_RD_PORTS; r++) begin
			o_rdat[r] = mem_q[i_rd_code[r]];
		end
	end

	assign o_prf_rdy = rdy_q;

endmodule

/* verilog/rsv_top.sv */
`timescale 1ns/1ps
`include "rsv_consts.svh"

module rsv_top (
	input  logic										clk,
	input  logic										i_arst_n,
	input  logic										i_flush,
	input  logic										i_dsp_vld,
	input  rsv_pkg::rsv_dsp_t							i_dsp_uop,
	input  rsv_pkg::rsv_wb_t [`WB_PORTS - 1 : 0]		i_wb,
	output logic										o_rsv_full,
	output rsv_pkg::rsv_issue_t [`ISSUE_PORTS - 1 : 0]	o_issue
);

	rsv_pkg::rsv_vec_t									alloc_vec;
	rsv_pkg::rsv_vec_t									alu_vld;
	rsv_pkg::rsv_vec_t									muldiv_vld;
	rsv_pkg::rsv_vec_t									alu_req;
	rsv_pkg::rsv_vec_t									muldiv_req;
	rsv_pkg::rsv_vec_t									oldest_alu;
	rsv_pkg::rsv_vec_t									oldest_muldiv;
	rsv_pkg::rsv_vec_t									issue_vec;
	rsv_pkg::rsv_vec_t									src_rdy;
	rsv_pkg::prf_code_t [`RSV_ENTRY_NUMS - 1 : 0]		src1_code;
	rsv_pkg::prf_code_t [`RSV_ENTRY_NUMS - 1 : 0]		src2_code;
	rsv_pkg::prf_code_t [`PRF_RD_PORTS - 1 : 0]			prf_rd_code;
	rsv_pkg::prf_data_t [`PRF_RD_PORTS - 1 : 0]			prf_rdat;
	logic [`PRF_NUMS - 1 : 0]							prf_rdy;

	rsv_ctrl u_ctrl (
		.clk				(clk),
		.i_arst_n			(i_arst_n),
		.i_flush			(i_flush),
		.i_dsp_vld			(i_dsp_vld),
		.i_dsp_uop			(i_dsp_uop),
		.i_src_rdy			(src_rdy),
		.i_src1_code		(src1_code),
		.i_src2_code		(src2_code),
		.i_oldest_alu		(oldest_alu),
		.i_oldest_muldiv	(oldest_muldiv),
		.i_prf_rdat			(prf_rdat),
		.o_alloc_vec		(alloc_vec),
		.o_alu_vld			(alu_vld),
		.o_muldiv_vld		(muldiv_vld),
		.o_alu_req			(alu_req),
		.o_muldiv_req		(muldiv_req),
		.o_issue_vec		(issue_vec),
		.o_prf_rd_code		(prf_rd_code),
		.o_rsv_full			(o_rsv_full),
		.o_issue			(o_issue)
	);

	rsv_src_tag u_src_tag (
		.clk				(clk),
		.i_arst_n			(i_arst_n),
		.i_alloc_vec		(alloc_vec),
		.i_dsp_uop			(i_dsp_uop),
		.i_prf_rdy			(prf_rdy),
		.i_wb				(i_wb),
		.i_issue_vec		(issue_vec),
		.o_src_rdy			(src_rdy),
		.o_src1_code		(src1_code),
		.o_src2_code		(src2_code)
	);

	rsv_age_mtrx u_alu_age (
		.clk				(clk),
		.i_arst_n			(i_arst_n),
		.i_flush			(i_flush),
		.i_alloc_vec		(alloc_vec),
		.i_alloc_mine		(i_dsp_uop.unit == rsv_pkg::EXEC_ALU),
		.i_entry_vld_vec	(alu_vld),
		.i_req_vec			(alu_req),
		.o_oldest_vec		(oldest_alu)
	);

	rsv_age_mtrx u_muldiv_age (
		.clk				(clk),
		.i_arst_n			(i_arst_n),
		.i_flush			(i_flush),
		.i_alloc_vec		(alloc_vec),
		.i_alloc_mine		(i_dsp_uop.unit == rsv_pkg::EXEC_MULDIV),
		.i_entry_vld_vec	(muldiv_vld),
		.i_req_vec			(muldiv_req),
		.o_oldest_vec		(oldest_muldiv)
	);

	// only accepted dispatches clear a destination ready bit
	rsv_prf u_prf (
		.clk				(clk),
		.i_arst_n			(i_arst_n),
		.i_wb				(i_wb),
		.i_dsp_vld			(|alloc_vec),
		.i_dsp_uop			(i_dsp_uop),
		.i_rd_code			(prf_rd_code),
		.o_rdat				(prf_rdat),
		.o_prf_rdy			(prf_rdy)
	);

endmodule

/* sim/rsv_tb.sv */
`timescale 1ns/1ps
`include "rsv_consts.svh"

module rsv_tb;

	localparam int CLK_HALF = 20;
	// every phase drains in well under a hundred cycles
	localparam int MAX_CYCLES = 2000;

	logic										clk;
	logic										i_arst_n;
	logic										i_flush;
	logic										i_dsp_vld;
	rsv_pkg::rsv_dsp_t							i_dsp_uop;
	rsv_pkg::rsv_wb_t [`WB_PORTS - 1 : 0]		i_wb;
	logic										o_rsv_full;
	rsv_pkg::rsv_issue_t [`ISSUE_PORTS - 1 : 0]	o_issue;

	// reference state
	rsv_pkg::prf_data_t		model_data [`PRF_NUMS];
	logic [`PRF_NUMS - 1 : 0]	model_rdy;
	rsv_pkg::rsv_issue_t	exp_q [`ISSUE_PORTS][$];
	rsv_pkg::rsv_dsp_t		wait_q [$];
	int						value_errs;
	int						other_errs;
	int						cycles;

	rsv_top u_rsv_top (
		.clk		(clk),
		.i_arst_n	(i_arst_n),
		.i_flush	(i_flush),
		.i_dsp_vld	(i_dsp_vld),
		.i_dsp_uop	(i_dsp_uop),
		.i_wb		(i_wb),
		.o_rsv_full	(o_rsv_full),
		.o_issue	(o_issue)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	function automatic logic srcs_ready(input rsv_pkg::rsv_dsp_t uop);
		return (!uop.src1_vld || model_rdy[uop.src1_code])
			&& (!uop.src2_vld || model_rdy[uop.src2_code]);
	endfunction

	function automatic rsv_pkg::rsv_issue_t expect_issue(input rsv_pkg::rsv_dsp_t uop);
		rsv_pkg::rsv_issue_t iss;
		iss.vld			= 1'b1;
		iss.rob_id		= uop.rob_id;
		iss.dst_vld		= uop.dst_vld;
		iss.dst_code	= uop.dst_code;
		iss.imm			= uop.imm;
		iss.src1_data	= model_data[uop.src1_code];
		iss.src2_data	= model_data[uop.src2_code];
		return iss;
	endfunction

	function automatic rsv_pkg::rsv_dsp_t make_uop(input rsv_pkg::exec_unit_e unit,
			input logic s1v, input int s1, input logic s2v, input int s2,
			input logic dv, input int d);
		rsv_pkg::rsv_dsp_t uop;
		uop.unit		= unit;
		uop.src1_vld	= s1v;
		uop.src1_code	= rsv_pkg::prf_code_t'(s1);
		uop.src2_vld	= s2v;
		uop.src2_code	= rsv_pkg::prf_code_t'(s2);
		uop.dst_vld		= dv;
		uop.dst_code	= rsv_pkg::prf_code_t'(d);
		uop.rob_id		= rsv_pkg::rob_id_t'($urandom);
		uop.imm			= rsv_pkg::imm_t'($urandom);
		return uop;
	endfunction

	task automatic drive_inputs(input logic dsp_vld, input rsv_pkg::rsv_dsp_t uop,
			input rsv_pkg::rsv_wb_t [`WB_PORTS - 1 : 0] wb, input logic flush);
		@(posedge clk);
		i_dsp_vld <= dsp_vld;
		i_dsp_uop <= uop;
		i_wb      <= wb;
		i_flush   <= flush;
	endtask

	task automatic idle(input int n);
		repeat (n) drive_inputs(1'b0, '0, '0, 1'b0);
	endtask

	task automatic dispatch(input rsv_pkg::rsv_dsp_t uop);
		drive_inputs(1'b1, uop, '0, 1'b0);
		if (srcs_ready(uop)) begin
			exp_q[int'(uop.unit)].push_back(expect_issue(uop));
		end else begin
			wait_q.push_back(uop);
		end
		if (uop.dst_vld) begin
			model_rdy[uop.dst_code] = 1'b0;
		end
	endtask

	// port 1 only writes when v1 is set
	task automatic write_back(input logic v1, input int c0, input int c1);
		rsv_pkg::rsv_wb_t [`WB_PORTS - 1 : 0] wb;
		int i;
		wb[0] = '{vld: 1'b1, code: rsv_pkg::prf_code_t'(c0), data: $urandom};
		wb[1] = '{vld: v1, code: rsv_pkg::prf_code_t'(c1), data: $urandom};
		drive_inputs(1'b0, '0, wb, 1'b0);
		for (int p = 0; p < `WB_PORTS; p++) begin
			if (wb[p].vld) begin
				model_data[wb[p].code] = wb[p].data;
				model_rdy[wb[p].code]  = 1'b1;
			end
		end
		// woken consumers, kept in dispatch order
		i = 0;
		while (i < wait_q.size()) begin
			if (srcs_ready(wait_q[i])) begin
				exp_q[int'(wait_q[i].unit)].push_back(expect_issue(wait_q[i]));
				wait_q.delete(i);
			end else begin
				i++;
			end
		end
	endtask

	task automatic wait_drain();
		while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
			idle(1);
		end
		idle(2);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			value_errs++;
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	always @(negedge clk) begin : check_issue
		rsv_pkg::rsv_issue_t head;
		if (i_arst_n) begin
			for (int p = 0; p < `ISSUE_PORTS; p++) begin
				if (o_issue[p].vld) begin
					assert (exp_q[p].size() != 0) else begin
						other_errs++;
						$display("%0t: port %0d issued a micro-op that should not issue",
							$time, p);
					end
					if (exp_q[p].size() != 0) begin
						head = exp_q[p].pop_front();
						assert (o_issue[p] == head) else begin
							value_errs++;
							$display("[ERROR] %0t o_issue[%0d] got %h expected %h",
								$time, p, o_issue[p], head);
						end
					end
				end
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		other_errs++;
		$display("timeout after %0d cycles with issues still outstanding", cycles);
		$display("errors: %0d value, %0d other", value_errs, other_errs);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		void'($urandom(32'hd1bc_dcd9));
		value_errs = 0;
		other_errs = 0;
		model_rdy  = '1;
		for (int r = 0; r < `PRF_NUMS; r++) begin
			model_data[r] = '0;
		end
		i_arst_n  = 1'b0;
		i_flush   = 1'b0;
		i_dsp_vld = 1'b0;
		i_dsp_uop = '0;
		i_wb      = '0;
		repeat (3) @(posedge clk);
		i_arst_n <= 1'b1;

		@(negedge clk);
		check_bit("o_rsv_full", o_rsv_full, 1'b0);
		check_bit("o_issue[0].vld", o_issue[0].vld, 1'b0);
		check_bit("o_issue[1].vld", o_issue[1].vld, 1'b0);

		// sources ready at dispatch
		for (int r = 1; r < 9; r += 2) begin
			write_back(1'b1, r, r + 1);
		end
		for (int i = 0; i < 6; i++) begin
			dispatch(make_uop(rsv_pkg::exec_unit_e'(i % 2), 1'b1, $urandom_range(8, 1),
				1'b1, $urandom_range(8, 1), 1'b1, 16 + i));
		end
		wait_drain();

		// consumer waits on p24
		dispatch(make_uop(rsv_pkg::EXEC_ALU, 1'b1, 1, 1'b0, 0, 1'b1, 24));
		dispatch(make_uop(rsv_pkg::EXEC_MULDIV, 1'b1, 24, 1'b1, 2, 1'b1, 25));
		idle(6);
		write_back(1'b0, 24, 0);
		wait_drain();

		// all woken by one writeback, issue by age
		dispatch(make_uop(rsv_pkg::EXEC_ALU, 1'b0, 0, 1'b0, 0, 1'b1, 26));
		for (int i = 0; i < 6; i++) begin
			dispatch(make_uop(i < 4 ? rsv_pkg::EXEC_ALU : rsv_pkg::EXEC_MULDIV,
				1'b1, 26, 1'b1, $urandom_range(8, 1), 1'b0, 0));
		end
		idle(3);
		write_back(1'b0, 26, 0);
		wait_drain();

		// p16 stays pending, so the station fills
		for (int i = 0; i < 8; i++) begin
			dispatch(make_uop(rsv_pkg::exec_unit_e'($urandom_range(1, 0)), 1'b1, 16,
				1'b0, 0, 1'b0, 0));
		end
		idle(1);
		@(negedge clk);
		check_bit("o_rsv_full", o_rsv_full, 1'b1);

		drive_inputs(1'b0, '0, '0, 1'b1);
		wait_q.delete();
		idle(1);
		@(negedge clk);
		check_bit("o_rsv_full", o_rsv_full, 1'b0);
		write_back(1'b0, 16, 0);
		idle(10);

		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+include
verilog/rsv_pkg.sv
verilog/rsv_age_mtrx.sv
verilog/rsv_src_tag.sv
verilog/rsv_ctrl.sv
verilog/rsv_prf.sv
verilog/rsv_top.sv
sim/rsv_tb.sv

/* Bender.yml */
package:
  name: rsv_station

export_include_dirs:
  - include

sources:
  - files:
      - verilog/rsv_pkg.sv
      - verilog/rsv_age_mtrx.sv
      - verilog/rsv_src_tag.sv
      - verilog/rsv_ctrl.sv
      - verilog/rsv_prf.sv
      - verilog/rsv_top.sv
  - target: test
    files:
      - sim/rsv_tb.sv
